// File: sim.f
+incdir+src
src/soc_bus_pkg.sv
src/soc_timer_pkg.sv
src/periph_bus_if.sv
src/wb_region_fsm.sv
src/clint_timer.sv
src/debug_req_unit.sv
src/boot_rom.sv
src/soc_ctrl_top.sv
sim/tb_soc_ctrl.sv

// File: sim/tb_soc_ctrl.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_soc_ctrl;

  localparam int bus_timeout = 50;
  localparam logic [31:0] rom_expected [`SOC_ROM_WORDS] = `SOC_ROM_TABLE;

  logic                      clk_i;
  logic                      ndmreset_n;
  logic                      rtc_i;
  logic                      wb_cyc_i;
  logic                      wb_stb_i;
  logic                      wb_we_i;
  logic [`SOC_WB_ADDR_W-1:0] wb_adr_i;
  logic [`SOC_WB_DATA_W-1:0] wb_dat_i;
  logic [`SOC_WB_DATA_W-1:0] wb_dat_o;
  logic                      wb_ack_o;
  logic                      wb_err_o;
  logic [`SOC_NUM_HARTS-1:0] timer_irq_o;
  logic [`SOC_NUM_HARTS-1:0] ipi_o;
  logic [`SOC_NUM_HARTS-1:0] debug_req_o;

  int                        checks;
  int                        errors;
  int                        test_first_error;
  int                        last_latency;
  logic [31:0]               last_rdata;
  logic [`SOC_NUM_HARTS-1:0] req_at_strobe;

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    rtc_i = 1'b0;
    forever #50 rtc_i = ~rtc_i;
  end

  soc_ctrl_top soc_ctrl_top_inst (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .wb_cyc_i    ( wb_cyc_i    ),
    .wb_stb_i    ( wb_stb_i    ),
    .wb_we_i     ( wb_we_i     ),
    .wb_adr_i    ( wb_adr_i    ),
    .wb_dat_i    ( wb_dat_i    ),
    .wb_dat_o    ( wb_dat_o    ),
    .wb_ack_o    ( wb_ack_o    ),
    .wb_err_o    ( wb_err_o    ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  // --------------------------------------------------
  // Bus protocol properties
  // --------------------------------------------------
  // Strobe seen on one edge, response visible three edges later
  a_fixed_latency : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $rose(wb_stb_i) |-> ##3 (wb_ack_o || wb_err_o))
    else begin
      errors++;
      $display("response did not come 2 cycles after the strobe at %0t", $time);
    end

  a_single_response : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(wb_ack_o && wb_err_o))
    else begin
      errors++;
      $display("ack and err were high together at %0t", $time);
    end

  a_response_in_cycle : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (wb_ack_o || wb_err_o) |-> (wb_cyc_i && wb_stb_i))
    else begin
      errors++;
      $display("response arrived outside a bus cycle at %0t", $time);
    end

  function automatic logic [15:0] clint_addr(input logic [11:0] off);
    return {`SOC_REGION_CLINT, off};
  endfunction

  function automatic logic [15:0] debug_addr(input logic [11:0] off);
    return {`SOC_REGION_DEBUG, off};
  endfunction

  task automatic check_equal(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic begin_test();
    test_first_error = errors;
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, errors - test_first_error);
  endtask

  // --------------------------------------------------
  // Wishbone classic master
  // --------------------------------------------------
  task automatic bus_access(input logic we, input logic [15:0] adr,
                            input logic [31:0] wdat, input logic exp_err);
    int n;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    n = 0;
    @(negedge clk_i);
    req_at_strobe = debug_req_o;
    while (!(wb_ack_o || wb_err_o) && n < bus_timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (!(wb_ack_o || wb_err_o)) begin
      errors++;
      $display("timeout: no ack or err for the access to address %h", adr);
    end
    check_equal("err response", wb_err_o, exp_err);
    last_rdata   = wb_dat_o;
    // n counts edges from the drive edge, the strobe is sampled one edge later
    last_latency = n - 1;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [15:0] adr, input logic [31:0] data);
    bus_access(1'b1, adr, data, 1'b0);
  endtask

  task automatic wb_read(input logic [15:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, 32'h0, 1'b0);
    data = last_rdata;
  endtask

  initial begin
    logic [`SOC_NUM_HARTS-1:0] mask;
    logic [31:0]               rd;
    logic [31:0]               t0;
    logic [31:0]               mt_lo;
    logic [31:0]               mt_hi;
    logic [31:0]               delta;
    int                        polls;
    void'($urandom(32'h2db4a288));
    checks     = 0;
    errors     = 0;
    ndmreset_n = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    repeat (3) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    begin_test();
    @(negedge clk_i);
    check_equal("outputs after reset",
                {wb_ack_o, wb_err_o, ipi_o, debug_req_o, timer_irq_o}, '0);
    bus_access(1'b0, 16'h3000, 32'h0, 1'b1);
    check_equal("err latency", last_latency, 2);
    bus_access(1'b1, {`SOC_REGION_ROM, 12'h008}, $urandom, 1'b1);
    bus_access(1'b0, 16'hf010, 32'h0, 1'b1);
    check_equal("err latency", last_latency, 2);
    report_test("reset and error response");

    // Halt mask goes in while the boot window is still open
    begin_test();
    mask = ($urandom % ((1 << `SOC_NUM_HARTS) - 1)) + 1;
    wb_write(debug_addr(`SOC_DEBUG_HALTREQ), 32'(mask));
    rd    = 32'd1;
    polls = 0;
    while (rd[0] && polls < 400) begin
      wb_read(debug_addr(`SOC_DEBUG_WINDOW), rd);
      if (rd[0]) check_equal("debug_req_o in window", req_at_strobe, '0);
      polls++;
    end
    if (rd[0]) begin
      errors++;
      $display("timeout: the boot delay window never closed");
    end
    check_equal("debug_req_o after window", debug_req_o, mask);
    wb_write(debug_addr(`SOC_DEBUG_HALTREQ), 32'h0);
    check_equal("debug_req_o cleared", debug_req_o, '0);
    report_test("boot delay window");

    begin_test();
    for (int i = 0; i < `SOC_ROM_WORDS; i++) begin
      wb_read({`SOC_REGION_ROM, 12'(4 * i)}, rd);
      check_equal("rom word", rd, rom_expected[i]);
      check_equal("ack latency", last_latency, 2);
    end
    wb_read({`SOC_REGION_ROM, 12'(4 * `SOC_ROM_WORDS)}, rd);
    check_equal("rom past table", rd, '0);
    report_test("rom reads");

    begin_test();
    for (int h = 0; h < `SOC_NUM_HARTS; h++) begin
      wb_write(clint_addr(`SOC_CLINT_MSIP_BASE + 12'(4 * h)), 32'd1);
      check_equal("ipi_o set", ipi_o, 1 << h);
      wb_read(clint_addr(`SOC_CLINT_MSIP_BASE + 12'(4 * h)), rd);
      check_equal("msip read", rd, 32'd1);
      wb_write(clint_addr(`SOC_CLINT_MSIP_BASE + 12'(4 * h)), 32'd0);
      check_equal("ipi_o cleared", ipi_o, '0);
    end
    report_test("software interrupts");

    // --------------------------------------------------
    // Machine time and compare
    // --------------------------------------------------
    begin_test();
    wb_read(clint_addr(`SOC_CLINT_MTIME), t0);
    repeat (50) @(posedge clk_i);
    wb_read(clint_addr(`SOC_CLINT_MTIME), rd);
    check_equal("mtime increased", rd > t0, 1'b1);
    // Top bits clear so the low half cannot carry
    mt_lo = $urandom & 32'h7fff_ffff;
    mt_hi = $urandom & 32'h7fff_ffff;
    wb_write(clint_addr(`SOC_CLINT_MTIME), mt_lo);
    wb_write(clint_addr(`SOC_CLINT_MTIME + 12'd4), mt_hi);
    wb_read(clint_addr(`SOC_CLINT_MTIME), rd);
    check_equal("mtime low read back", (rd >= mt_lo) && (rd - mt_lo < 8), 1'b1);
    wb_read(clint_addr(`SOC_CLINT_MTIME + 12'd4), rd);
    check_equal("mtime high read back", rd, mt_hi);
    for (int h = 0; h < `SOC_NUM_HARTS; h++) begin
      wb_read(clint_addr(`SOC_CLINT_MTIME), rd);
      delta = 6 + ($urandom % 10);
      wb_write(clint_addr(`SOC_CLINT_MTIMECMP_BASE + 12'(8 * h)), rd + delta);
      wb_write(clint_addr(`SOC_CLINT_MTIMECMP_BASE + 12'(8 * h + 4)), mt_hi);
      check_equal("timer_irq_o before compare", timer_irq_o[h], 1'b0);
      polls = 0;
      while (!timer_irq_o[h] && polls < 2000) begin
        @(negedge clk_i);
        polls++;
      end
      if (!timer_irq_o[h]) begin
        errors++;
        $display("timeout: timer_irq_o[%0d] never rose", h);
      end
      wb_write(clint_addr(`SOC_CLINT_MTIMECMP_BASE + 12'(8 * h + 4)), 32'hffff_ffff);
      check_equal("timer_irq_o after compare reset", timer_irq_o[h], 1'b0);
    end
    report_test("machine time and timer interrupt");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: src/soc_ctrl_top.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module soc_ctrl_top (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic                      rtc_i,
  // Wishbone classic slave
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`SOC_WB_ADDR_W-1:0] wb_adr_i,
  input  logic [`SOC_WB_DATA_W-1:0] wb_dat_i,
  output logic [`SOC_WB_DATA_W-1:0] wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,
  // Per-hart lines to the cores
  output soc_timer_pkg::hart_vec_t  timer_irq_o,
  output soc_timer_pkg::hart_vec_t  ipi_o,
  output soc_timer_pkg::hart_vec_t  debug_req_o
);

  periph_bus_if rom_bus ();
  periph_bus_if clint_bus ();
  periph_bus_if debug_bus ();

  // --------------------------------------------------
  // Bus slave and region decoder
  // --------------------------------------------------
  wb_region_fsm i_wb_region_fsm (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .wb_cyc_i   ( wb_cyc_i   ),
    .wb_stb_i   ( wb_stb_i   ),
    .wb_we_i    ( wb_we_i    ),
    .wb_adr_i   ( wb_adr_i   ),
    .wb_dat_i   ( wb_dat_i   ),
    .wb_dat_o   ( wb_dat_o   ),
    .wb_ack_o   ( wb_ack_o   ),
    .wb_err_o   ( wb_err_o   ),
    .rom_o      ( rom_bus    ),
    .clint_o    ( clint_bus  ),
    .debug_o    ( debug_bus  )
  );

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  boot_rom i_boot_rom (
    .bus_i ( rom_bus )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .bus_i       ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_unit i_debug_req_unit (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .bus_i       ( debug_bus   ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: src/boot_rom.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module boot_rom (
  periph_bus_if.target bus_i
);

  localparam int unsigned IdxW = $clog2(`SOC_ROM_WORDS);

  // --------------------------------------------------
  // Boot word table
  // --------------------------------------------------
  localparam logic [`SOC_WB_DATA_W-1:0] RomTable [`SOC_ROM_WORDS] = `SOC_ROM_TABLE;

  logic [IdxW-1:0] word_idx;
  logic            in_table;

  // Word addressed, low two bits ignored
  assign word_idx = bus_i.offset[2 +: IdxW];
  assign in_table = (bus_i.offset >> (IdxW + 2)) == '0;

  always_comb begin
    if (in_table) begin
      bus_i.rdata = RomTable[word_idx];
    end else begin
      bus_i.rdata = '0;
    end
  end

endmodule

// File: src/debug_req_unit.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module debug_req_unit (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  periph_bus_if.target             bus_i,
  output soc_timer_pkg::hart_vec_t debug_req_o
);

  localparam int unsigned CntW = $clog2(`SOC_DEBUG_DELAY_CYCLES + 1);

  logic [CntW-1:0]          delay_cnt_q;
  soc_timer_pkg::hart_vec_t halt_q;
  logic                     window_open;
  logic                     halt_wr;

  // --------------------------------------------------
  // Boot delay window keeps boot code undisturbed
  // --------------------------------------------------
  assign window_open = delay_cnt_q != '0;
  assign halt_wr     = bus_i.req && bus_i.we && (bus_i.offset == `SOC_DEBUG_HALTREQ);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      delay_cnt_q <= CntW'(`SOC_DEBUG_DELAY_CYCLES);
      halt_q      <= '0;
    end else begin
      if (window_open) delay_cnt_q <= delay_cnt_q - 1'b1;
      if (halt_wr)     halt_q <= bus_i.wdata[`SOC_NUM_HARTS-1:0];
    end
  end

  always_comb begin
    bus_i.rdata = '0;
    case (bus_i.offset)
      `SOC_DEBUG_HALTREQ: bus_i.rdata[`SOC_NUM_HARTS-1:0] = halt_q;
      `SOC_DEBUG_WINDOW:  bus_i.rdata[0] = window_open;
      default:            bus_i.rdata = '0;
    endcase
  end

  // Requests held back until the window closes
  assign debug_req_o = window_open ? '0 : halt_q;

  // No request reaches a hart sooner than the delay after reset release
  a_no_req_in_window : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (debug_req_o != '0) |-> $past(ndmreset_n, `SOC_DEBUG_DELAY_CYCLES));

endmodule

// File: src/clint_timer.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module clint_timer (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  logic                     rtc_i,
  periph_bus_if.target             bus_i,
  output soc_timer_pkg::hart_vec_t timer_irq_o,
  output soc_timer_pkg::hart_vec_t ipi_o
);

  logic [1:0]                rtc_sync_q;
  logic                      rtc_prev_q;
  logic                      rtc_div_q;
  logic                      rtc_rise;
  logic                      mtime_tick;
  soc_timer_pkg::mtime_u     mtime_q;
  soc_timer_pkg::mtime_u     mtimecmp_q [`SOC_NUM_HARTS];
  soc_timer_pkg::hart_vec_t  msip_q;
  soc_timer_pkg::hart_vec_t  hit_msip;
  soc_timer_pkg::hart_vec_t  hit_cmp_lo;
  soc_timer_pkg::hart_vec_t  hit_cmp_hi;
  logic                      hit_mtime_lo;
  logic                      hit_mtime_hi;
  logic                      wr;
  logic                      mtime_wr;

  // --------------------------------------------------
  // RTC sampling, divide by two
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) rtc_div_q <= ~rtc_div_q;
    end
  end

  assign rtc_rise   = rtc_sync_q[1] & ~rtc_prev_q;
  assign mtime_tick = rtc_rise & rtc_div_q;

  // Register decode
  always_comb begin
    for (int h = 0; h < `SOC_NUM_HARTS; h++) begin
      hit_msip[h]   = bus_i.offset == `SOC_CLINT_MSIP_BASE + 12'(4 * h);
      hit_cmp_lo[h] = bus_i.offset == `SOC_CLINT_MTIMECMP_BASE + 12'(8 * h);
      hit_cmp_hi[h] = bus_i.offset == `SOC_CLINT_MTIMECMP_BASE + 12'(8 * h + 4);
    end
    hit_mtime_lo = bus_i.offset == `SOC_CLINT_MTIME;
    hit_mtime_hi = bus_i.offset == `SOC_CLINT_MTIME + 12'd4;
  end

  always_comb begin
    bus_i.rdata = '0;
    for (int h = 0; h < `SOC_NUM_HARTS; h++) begin
      if (hit_msip[h])   bus_i.rdata[0] = msip_q[h];
      if (hit_cmp_lo[h]) bus_i.rdata = mtimecmp_q[h].half.lo;
      if (hit_cmp_hi[h]) bus_i.rdata = mtimecmp_q[h].half.hi;
    end
    if (hit_mtime_lo) bus_i.rdata = mtime_q.half.lo;
    if (hit_mtime_hi) bus_i.rdata = mtime_q.half.hi;
  end

  assign wr       = bus_i.req && bus_i.we;
  assign mtime_wr = wr && (hit_mtime_lo || hit_mtime_hi);

  // --------------------------------------------------
  // Time, compare and software interrupt registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q.count <= '0;
      msip_q        <= '0;
      timer_irq_o   <= '0;
      for (int h = 0; h < `SOC_NUM_HARTS; h++) begin
        mtimecmp_q[h].count <= '1;
      end
    end else begin
      // Bus write wins over the tick
      if (wr && hit_mtime_lo) begin
        mtime_q.half.lo <= bus_i.wdata;
      end else if (wr && hit_mtime_hi) begin
        mtime_q.half.hi <= bus_i.wdata;
      end else if (mtime_tick) begin
        mtime_q.count <= mtime_q.count + 64'd1;
      end
      for (int h = 0; h < `SOC_NUM_HARTS; h++) begin
        if (wr && hit_cmp_lo[h]) mtimecmp_q[h].half.lo <= bus_i.wdata;
        if (wr && hit_cmp_hi[h]) mtimecmp_q[h].half.hi <= bus_i.wdata;
        if (wr && hit_msip[h])   msip_q[h] <= bus_i.wdata[0];
        timer_irq_o[h] <= mtime_q.count >= mtimecmp_q[h].count;
      end
    end
  end

  assign ipi_o = msip_q;

  a_mtime_monotonic : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !mtime_wr |=> mtime_q.count >= $past(mtime_q.count));

endmodule

// File: src/wb_region_fsm.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module wb_region_fsm (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`SOC_WB_ADDR_W-1:0] wb_adr_i,
  input  logic [`SOC_WB_DATA_W-1:0] wb_dat_i,
  output logic [`SOC_WB_DATA_W-1:0] wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,
  periph_bus_if.controller          rom_o,
  periph_bus_if.controller          clint_o,
  periph_bus_if.controller          debug_o
);

  typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} state_e;

  state_e                  state_q;
  soc_bus_pkg::bus_addr_t  adr;
  soc_bus_pkg::region_e    region;
  soc_bus_pkg::region_e    region_q;
  soc_bus_pkg::offset_t    offset_q;
  soc_bus_pkg::word_t      wdata_q;
  soc_bus_pkg::word_t      rdata_q;
  soc_bus_pkg::word_t      rdata_sel;
  logic                    we_q;
  logic                    bad_q;
  logic                    start;
  logic                    access;

  assign adr = wb_adr_i;

  // --------------------------------------------------
  // Region decode
  // --------------------------------------------------
  always_comb begin
    case (adr.region)
      `SOC_REGION_ROM:   region = soc_bus_pkg::REGION_ROM;
      `SOC_REGION_CLINT: region = soc_bus_pkg::REGION_CLINT;
      `SOC_REGION_DEBUG: region = soc_bus_pkg::REGION_DEBUG;
      default:           region = soc_bus_pkg::REGION_NONE;
    endcase
  end

  // Strobe is still up during the response cycle, skip it
  assign start  = (state_q == IDLE) && wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign access = (state_q == ACCESS) && !bad_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q  <= IDLE;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      case (state_q)
        IDLE:    if (start) state_q <= ACCESS;
        ACCESS:  state_q <= RESPOND;
        RESPOND: begin
          state_q  <= IDLE;
          wb_ack_o <= !bad_q;
          wb_err_o <= bad_q;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      region_q <= region;
      offset_q <= adr.offset;
      we_q     <= wb_we_i;
      wdata_q  <= wb_dat_i;
      // ROM is read only
      bad_q    <= (region == soc_bus_pkg::REGION_NONE) ||
                  ((region == soc_bus_pkg::REGION_ROM) && wb_we_i);
    end
    if (state_q == ACCESS) begin
      rdata_q <= we_q ? '0 : rdata_sel;
    end
  end

  always_comb begin
    case (region_q)
      soc_bus_pkg::REGION_ROM:   rdata_sel = rom_o.rdata;
      soc_bus_pkg::REGION_CLINT: rdata_sel = clint_o.rdata;
      soc_bus_pkg::REGION_DEBUG: rdata_sel = debug_o.rdata;
      default:                   rdata_sel = '0;
    endcase
  end

  assign wb_dat_o = rdata_q;

  // --------------------------------------------------
  // Target strobes
  // --------------------------------------------------
  assign rom_o.req     = access && (region_q == soc_bus_pkg::REGION_ROM);
  assign rom_o.we      = we_q;
  assign rom_o.offset  = offset_q;
  assign rom_o.wdata   = wdata_q;

  assign clint_o.req    = access && (region_q == soc_bus_pkg::REGION_CLINT);
  assign clint_o.we     = we_q;
  assign clint_o.offset = offset_q;
  assign clint_o.wdata  = wdata_q;

  assign debug_o.req    = access && (region_q == soc_bus_pkg::REGION_DEBUG);
  assign debug_o.we     = we_q;
  assign debug_o.offset = offset_q;
  assign debug_o.wdata  = wdata_q;

  a_one_response : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(wb_ack_o && wb_err_o));

  a_single_cycle_response : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o));

endmodule

// File: src/periph_bus_if.sv
`timescale 1ns/1ps

interface periph_bus_if;

  // One cycle strobe per access
  logic                  req;
  logic                  we;
  soc_bus_pkg::offset_t  offset;
  soc_bus_pkg::word_t    wdata;
  // Combinational from offset
  soc_bus_pkg::word_t    rdata;

  modport controller (
    output req,
    output we,
    output offset,
    output wdata,
    input  rdata
  );

  modport target (
    input  req,
    input  we,
    input  offset,
    input  wdata,
    output rdata
  );

endinterface

// File: src/soc_timer_pkg.sv
`include "soc_consts.svh"

package soc_timer_pkg;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } mtime_half_t;

  // Counter view for increment and compare, half view for bus access
  typedef union packed {
    logic [63:0] count;
    mtime_half_t half;
  } mtime_u;

  // One bit per hart
  typedef logic [`SOC_NUM_HARTS-1:0] hart_vec_t;

endpackage

// File: src/soc_bus_pkg.sv
`include "soc_consts.svh"

package soc_bus_pkg;

  // --------------------------------------------------
  // Data and offset words seen by every target
  // --------------------------------------------------
  typedef logic [`SOC_WB_DATA_W-1:0] word_t;
  typedef logic [`SOC_OFFSET_W-1:0]  offset_t;

  // Decoded target of one access
  typedef enum logic [1:0] {
    REGION_ROM   = 2'd0,
    REGION_CLINT = 2'd1,
    REGION_DEBUG = 2'd2,
    REGION_NONE  = 2'd3
  } region_e;

  // --------------------------------------------------
  // Wishbone address split into region and offset
  // --------------------------------------------------
  typedef struct packed {
    logic [`SOC_WB_ADDR_W-`SOC_OFFSET_W-1:0] region;
    offset_t                                 offset;
  } bus_addr_t;

endpackage

// File: src/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus and hart geometry
`define SOC_NUM_HARTS 2
`define SOC_WB_ADDR_W 16
`define SOC_WB_DATA_W 32
`define SOC_OFFSET_W  12

// Region codes in the top four address bits
`define SOC_REGION_ROM   4'd0
`define SOC_REGION_CLINT 4'd1
`define SOC_REGION_DEBUG 4'd2

// CLINT map, msip one word per hart, mtimecmp low then high per hart
`define SOC_CLINT_MSIP_BASE     12'h000
`define SOC_CLINT_MTIMECMP_BASE 12'h400
`define SOC_CLINT_MTIME         12'hFF8

// Debug request map
`define SOC_DEBUG_HALTREQ      12'h000
`define SOC_DEBUG_WINDOW       12'h004
`define SOC_DEBUG_DELAY_CYCLES 500

`define SOC_ROM_WORDS 16
`define SOC_ROM_TABLE '{ \
  32'hf1402573, 32'h00000597, 32'h03c58593, 32'h00000297, \
  32'h02c28293, 32'h0002a303, 32'h00030067, 32'h10500073, \
  32'hffdff06f, 32'h00000013, 32'h00000013, 32'h00000013, \
  32'h80000000, 32'h00000000, 32'h0b007e57, 32'hd00dfeed  \
}

`endif
